//--- raycast_pkg.sv
package raycast_pkg;

    // field widths of the column word and frame buffer
    localparam int HCOUNT_W   = 9;
    localparam int ROW_W      = 8;
    localparam int MAP_DATA_W = 5;
    localparam int WALL_X_W   = 16;
    localparam int FB_ADDR_W  = 16;  // 320*180 = 57600 words
    localparam int COLOR_W    = 8;   // palette index

    // screen geometry
    localparam logic [HCOUNT_W-1:0] SCREEN_WIDTH       = 9'd320;
    localparam logic [ROW_W-1:0]    SCREEN_HEIGHT      = 8'd180;
    localparam logic [ROW_W-1:0]    HALF_SCREEN_HEIGHT = SCREEN_HEIGHT >> 1;
    localparam logic [ROW_W-1:0]    LAST_ROW           = SCREEN_HEIGHT - 8'd1;

    // both frame buffers report ready on this value
    localparam logic [1:0] FB_BOTH_READY = 2'b11;

    // hedge palette, maps 0 and 2
    localparam logic [COLOR_W-1:0] SKY_HEDGE   = 8'd249;
    localparam logic [COLOR_W-1:0] FLOOR_HEDGE = 8'd239;

    // pig palette, maps 1 and 3
    localparam logic [COLOR_W-1:0] SKY_PIG     = 8'd38;
    localparam logic [COLOR_W-1:0] FLOOR_PIG   = 8'd45;

    localparam logic [COLOR_W-1:0] SOLID_COLOR = 8'd14;  // same on every map

    // neon walls, one per code 23..26
    localparam logic [COLOR_W-1:0] NEON_YELLOW = 8'd21;
    localparam logic [COLOR_W-1:0] NEON_BLUE   = 8'd48;
    localparam logic [COLOR_W-1:0] NEON_GREEN  = 8'd32;
    localparam logic [COLOR_W-1:0] NEON_PINK   = 8'd181;

    // map cell codes
    localparam logic [MAP_DATA_W-1:0] MAP_EMPTY      = 5'd0;
    localparam logic [MAP_DATA_W-1:0] MAP_SOLID      = 5'd1;
    localparam logic [MAP_DATA_W-1:0] MAP_NEON_FIRST = 5'd23;
    localparam logic [MAP_DATA_W-1:0] MAP_NEON_LAST  = 5'd26;

    // ray-march fifo word, msb first
    typedef struct packed {
        logic [HCOUNT_W-1:0]   hcount;       // screen column
        logic [ROW_W-1:0]      line_height;  // projected wall height in rows
        logic                  wall_type;    // 0 x side, 1 y side
        logic [MAP_DATA_W-1:0] map_data;     // cell code that was hit
        logic [WALL_X_W-1:0]   wall_x;       // hit position along the wall
    } column_t;

    // one row in flight out of the sequencer
    typedef struct packed {
        logic              valid;
        logic [ROW_W-1:0]  row;
        logic              last;    // row 179 of a tlast column
        column_t           column;
    } row_step_t;

    // frame buffer word
    typedef struct packed {
        logic               shade;
        logic [COLOR_W-1:0] color;
    } fb_pixel_t;

    // color stage result
    typedef struct packed {
        logic      valid;
        logic      last;
        fb_pixel_t pixel;
    } pixel_stage_t;

    // address stage result
    typedef struct packed {
        logic                 valid;
        logic [FB_ADDR_W-1:0] addr;
    } addr_stage_t;

endpackage

//--- column_sequencer.sv
module column_sequencer (
    input  logic                   pixel_clk_in,
    input  logic                   rst_in,
    input  logic                   dda_fifo_tvalid,
    input  raycast_pkg::column_t   dda_fifo_tdata,
    input  logic                   dda_fifo_tlast,
    input  logic [1:0]             fb_ready_to_switch,
    output logic                   dda_fifo_tready,
    output raycast_pkg::row_step_t step
);
    import raycast_pkg::*;

    typedef enum logic [1:0] {
        WAIT_COLUMN,  // idle, fifo may hand over a column
        WALK_ROWS,    // one row per cycle
        WAIT_SWITCH   // frame done, hold off until buffers swap
    } seq_state_t;

    seq_state_t       state;
    logic [ROW_W-1:0] row;        // current row of the column
    column_t          column_q;   // captured fifo word
    logic             tlast_q;    // captured packet end
    logic             last_row;
    logic             accept;

    assign last_row = (row == LAST_ROW);

    // ready on idle, and on the final row so columns run back to back
    always_comb begin
        case (state)
            WAIT_COLUMN: dda_fifo_tready = 1'b1;
            WALK_ROWS:   dda_fifo_tready = last_row && !tlast_q;  // no early accept after tlast
            default:     dda_fifo_tready = 1'b0;
        endcase
    end

    assign accept = dda_fifo_tvalid && dda_fifo_tready;

    // control
    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            state <= WAIT_COLUMN;
            row   <= '0;
        end else begin
            case (state)
                WAIT_COLUMN: begin
                    if (accept) begin
                        state <= WALK_ROWS;
                        row   <= '0;
                    end
                end
                WALK_ROWS: begin
                    if (!last_row) begin
                        row <= row + 8'd1;
                    end else begin
                        row <= '0;
                        if (accept) begin
                            state <= WALK_ROWS;    // next column starts right away
                        end else if (tlast_q) begin
                            state <= WAIT_SWITCH;
                        end else begin
                            state <= WAIT_COLUMN;
                        end
                    end
                end
                WAIT_SWITCH: begin
                    if (fb_ready_to_switch == FB_BOTH_READY) begin
                        state <= WAIT_COLUMN;      // tready rises the cycle after
                    end
                end
                default: state <= WAIT_COLUMN;
            endcase
        end
    end

    // payload, loaded only on a handshake
    always_ff @(posedge pixel_clk_in) begin
        if (accept) begin
            column_q <= dda_fifo_tdata;
            tlast_q  <= dda_fifo_tlast;
        end
    end

    always_comb begin
        step.valid  = (state == WALK_ROWS);
        step.row    = row;
        step.last   = (state == WALK_ROWS) && tlast_q && last_row;  // marks the frame's final pixel
        step.column = column_q;
    end

    // rows follow each other with no gap until the closing row
    a_rows_contiguous: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
        step.valid && (step.row != LAST_ROW) |=> step.valid && (step.row == $past(step.row) + 8'd1));

    a_row_in_range: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
        row <= LAST_ROW);

endmodule

//--- color_picker.sv
module color_picker (
    input  logic                      pixel_clk_in,
    input  logic                      rst_in,
    input  raycast_pkg::row_step_t    step,
    input  logic [1:0]                map_select,
    output raycast_pkg::pixel_stage_t pixel_stage
);
    import raycast_pkg::*;

    typedef enum logic [1:0] {
        REGION_SKY,
        REGION_FLOOR,
        REGION_WALL
    } region_t;

    logic [ROW_W-1:0]   half_height;
    logic [ROW_W-1:0]   draw_start;   // first wall row
    logic [ROW_W-1:0]   draw_end;     // first floor row
    region_t            region;
    logic [COLOR_W-1:0] sky_color;
    logic [COLOR_W-1:0] floor_color;
    logic [COLOR_W-1:0] wall_color;
    fb_pixel_t          pixel_next;

    // wall band centred on row 90, at most 0..179 for height 180
    assign half_height = step.column.line_height >> 1;
    assign draw_start  = HALF_SCREEN_HEIGHT - half_height;
    assign draw_end    = HALF_SCREEN_HEIGHT + half_height;

    always_comb begin
        if (step.row < draw_start) begin
            region = REGION_SKY;
        end else if (step.row >= draw_end) begin
            region = REGION_FLOOR;   // height 0 gives sky above 90, floor below
        end else begin
            region = REGION_WALL;
        end
    end

    // bit 0 of map_select picks the palette
    always_comb begin
        if (map_select[0]) begin
            sky_color   = SKY_PIG;
            floor_color = FLOOR_PIG;
        end else begin
            sky_color   = SKY_HEDGE;
            floor_color = FLOOR_HEDGE;
        end
    end

    always_comb begin
        case (step.column.map_data)
            MAP_EMPTY:              wall_color = sky_color;    // see-through cell
            MAP_SOLID:              wall_color = SOLID_COLOR;
            MAP_NEON_FIRST:         wall_color = NEON_YELLOW;
            MAP_NEON_FIRST + 5'd1:  wall_color = NEON_BLUE;
            MAP_NEON_FIRST + 5'd2:  wall_color = NEON_GREEN;
            MAP_NEON_LAST:          wall_color = NEON_PINK;
            default:                wall_color = SOLID_COLOR;  // textured codes drawn flat
        endcase
    end

    always_comb begin
        case (region)
            REGION_SKY:   pixel_next = '{shade: 1'b0, color: sky_color};
            REGION_FLOOR: pixel_next = '{shade: 1'b0, color: floor_color};
            default:      pixel_next = '{shade: step.column.wall_type, color: wall_color};
        endcase
    end

    always_ff @(posedge pixel_clk_in) begin
        pixel_stage.pixel <= pixel_next;
        if (rst_in) begin
            pixel_stage.valid <= 1'b0;
            pixel_stage.last  <= 1'b0;
        end else begin
            pixel_stage.valid <= step.valid;
            pixel_stage.last  <= step.valid && step.last;
        end
    end

    // taller walls would wrap the bounds
    a_height_in_range: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
        step.valid |-> step.column.line_height <= SCREEN_HEIGHT);

endmodule

//--- address_generator.sv
module address_generator (
    input  logic                     pixel_clk_in,
    input  logic                     rst_in,
    input  raycast_pkg::row_step_t   step,
    output raycast_pkg::addr_stage_t addr_stage
);
    import raycast_pkg::*;

    logic [FB_ADDR_W-1:0] row_ext;
    logic [FB_ADDR_W-1:0] row_offset;
    logic [FB_ADDR_W-1:0] addr_next;

    assign row_ext = FB_ADDR_W'(step.row);

    // row * 320 as row * 256 + row * 64
    assign row_offset = (row_ext << 8) + (row_ext << 6);

    // largest is 319 + 179 * 320, fits in 16 bits
    assign addr_next = row_offset + FB_ADDR_W'(step.column.hcount);

    always_ff @(posedge pixel_clk_in) begin
        addr_stage.addr <= addr_next;
        if (rst_in) begin
            addr_stage.valid <= 1'b0;
        end else begin
            addr_stage.valid <= step.valid;
        end
    end

    // an off-screen column would land in the next row
    a_hcount_on_screen: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
        step.valid |-> step.column.hcount < SCREEN_WIDTH);

endmodule

//--- pixel_writer.sv
module pixel_writer (
    input  logic                                   pixel_clk_in,
    input  logic                                   rst_in,
    input  raycast_pkg::pixel_stage_t              pixel_stage,
    input  raycast_pkg::addr_stage_t               addr_stage,
    output logic [raycast_pkg::FB_ADDR_W-1:0]      ray_address,
    output raycast_pkg::fb_pixel_t                 ray_pixel,
    output logic                                   ray_pixel_valid,
    output logic                                   ray_last_pixel
);

    // merge both stages into one frame buffer write
    always_ff @(posedge pixel_clk_in) begin
        ray_address <= addr_stage.addr;
        ray_pixel   <= pixel_stage.pixel;
        if (rst_in) begin
            ray_pixel_valid <= 1'b0;
            ray_last_pixel  <= 1'b0;
        end else begin
            ray_pixel_valid <= pixel_stage.valid;                      // write strobe
            ray_last_pixel  <= pixel_stage.valid && pixel_stage.last;  // frame done
        end
    end

    // color and address paths have equal latency
    a_stages_aligned: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
        pixel_stage.valid == addr_stage.valid);

    // frame end is a single pulse
    a_last_is_pulse: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
        ray_last_pixel |=> !ray_last_pixel);

endmodule

//--- column_flattener.sv
module column_flattener (
    input  logic                              pixel_clk_in,
    input  logic                              rst_in,
    input  logic                              dda_fifo_tvalid,
    input  raycast_pkg::column_t              dda_fifo_tdata,
    input  logic                              dda_fifo_tlast,
    output logic                              dda_fifo_tready,
    input  logic [1:0]                        fb_ready_to_switch,
    input  logic [1:0]                        map_select,
    output logic [raycast_pkg::FB_ADDR_W-1:0] ray_address,
    output raycast_pkg::fb_pixel_t            ray_pixel,
    output logic                              ray_pixel_valid,
    output logic                              ray_last_pixel
);
    import raycast_pkg::*;

    row_step_t    step;         // row in flight
    pixel_stage_t pixel_stage;  // shaded color, 1 cycle later
    addr_stage_t  addr_stage;   // buffer address, 1 cycle later

    column_sequencer i_column_sequencer (
        .pixel_clk_in       (pixel_clk_in),
        .rst_in             (rst_in),
        .dda_fifo_tvalid    (dda_fifo_tvalid),
        .dda_fifo_tdata     (dda_fifo_tdata),
        .dda_fifo_tlast     (dda_fifo_tlast),
        .fb_ready_to_switch (fb_ready_to_switch),
        .dda_fifo_tready    (dda_fifo_tready),
        .step               (step)
    );

    color_picker i_color_picker (
        .pixel_clk_in (pixel_clk_in),
        .rst_in       (rst_in),
        .step         (step),
        .map_select   (map_select),
        .pixel_stage  (pixel_stage)
    );

    address_generator i_address_generator (
        .pixel_clk_in (pixel_clk_in),
        .rst_in       (rst_in),
        .step         (step),
        .addr_stage   (addr_stage)
    );

    pixel_writer i_pixel_writer (
        .pixel_clk_in    (pixel_clk_in),
        .rst_in          (rst_in),
        .pixel_stage     (pixel_stage),
        .addr_stage      (addr_stage),
        .ray_address     (ray_address),
        .ray_pixel       (ray_pixel),
        .ray_pixel_valid (ray_pixel_valid),
        .ray_last_pixel  (ray_last_pixel)
    );

endmodule

//--- column_flattener_checker.sv
module column_flattener_checker (
    input  logic                              pixel_clk_in,
    input  logic                              rst_in,
    input  logic                              dda_fifo_tvalid,
    input  raycast_pkg::column_t              dda_fifo_tdata,
    input  logic                              dda_fifo_tlast,
    input  logic                              dda_fifo_tready,
    input  logic [1:0]                        fb_ready_to_switch,
    input  logic [1:0]                        map_select,
    input  logic [raycast_pkg::FB_ADDR_W-1:0] ray_address,
    input  raycast_pkg::fb_pixel_t            ray_pixel,
    input  logic                              ray_pixel_valid,
    input  logic                              ray_last_pixel,
    input  logic                              run_done,
    output int                                value_errors,
    output int                                protocol_errors
);
    timeunit 1ns;
    timeprecision 1ps;
    import raycast_pkg::*;

    typedef struct packed {
        logic [15:0] addr;
        fb_pixel_t   pixel;
        logic        last;
    } write_t;

    write_t expected_q[$];   // one entry per frame buffer write still to come
    logic   seen_accept;     // first column taken
    logic   switch_pending;  // tlast column accepted, buffers not yet swapped
    logic   expect_ready;    // tready due on this edge
    logic   drain_checked;
    int     since_tlast;     // edges since the tlast accept

    // expected write for one row, straight from the palette and region rules
    function automatic write_t expected_write(column_t col, int row, logic [1:0] map_sel,
                                              logic tlast);
        write_t     w;
        int         half;
        int         code;
        logic [7:0] sky;
        logic [7:0] ground;
        logic [7:0] wall;
        half   = int'(col.line_height) / 2;
        code   = int'(col.map_data);
        sky    = (map_sel == 2'd1 || map_sel == 2'd3) ? 8'd38 : 8'd249;
        ground = (map_sel == 2'd1 || map_sel == 2'd3) ? 8'd45 : 8'd239;
        if (code == 0) wall = sky;
        else if (code == 23) wall = 8'd21;
        else if (code == 24) wall = 8'd48;
        else if (code == 25) wall = 8'd32;
        else if (code == 26) wall = 8'd181;
        else wall = 8'd14;  // solid, textured codes included
        if (row < 90 - half) w.pixel = '{shade: 1'b0, color: sky};
        else if (row >= 90 + half) w.pixel = '{shade: 1'b0, color: ground};
        else w.pixel = '{shade: col.wall_type, color: wall};
        w.addr = 16'(int'(col.hcount) + row * 320);
        w.last = tlast && (row == 179);
        return w;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERROR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        value_errors++;
    endtask

    task automatic report_protocol(input string what);
        $display("protocol error at %0t: %s", $time, what);
        protocol_errors++;
    endtask

    always @(posedge pixel_clk_in) begin
        write_t exp_w;
        if (rst_in) begin
            expected_q.delete();
            value_errors    = 0;
            protocol_errors = 0;
            seen_accept     = 1'b0;
            switch_pending  = 1'b0;
            expect_ready    = 1'b0;
            drain_checked   = 1'b0;
            since_tlast     = 0;
        end else begin
            if (!seen_accept && !dda_fifo_tready) begin
                report_protocol("tready low before the first column");
            end
            if (!seen_accept && (ray_pixel_valid || ray_last_pixel))
                report_protocol("write strobe or last pulse before any column was accepted");
            if (ray_pixel_valid) begin
                if (expected_q.size() == 0) begin
                    report_protocol("frame buffer write with no expected write queued");
                end else begin
                    exp_w = expected_q.pop_front();
                    if (ray_address != exp_w.addr) begin
                        report_mismatch("ray_address", 32'(ray_address), 32'(exp_w.addr));
                    end
                    if (ray_pixel != exp_w.pixel) begin
                        report_mismatch("ray_pixel", 32'(ray_pixel), 32'(exp_w.pixel));
                    end
                    if (ray_last_pixel != exp_w.last)
                        report_mismatch("ray_last_pixel", 32'(ray_last_pixel), 32'(exp_w.last));
                end
            end else if (ray_last_pixel) begin
                report_protocol("ray_last_pixel pulsed without a write");
            end
            if (expect_ready && !dda_fifo_tready) begin
                report_protocol("tready did not rise after the frame switch");
            end
            expect_ready = 1'b0;
            if (switch_pending) begin
                since_tlast++;
                if (dda_fifo_tvalid && dda_fifo_tready)
                    report_protocol("column accepted while waiting for the frame switch");
                else if (dda_fifo_tready)
                    report_protocol("tready high while waiting for the frame switch");
                // the sequencer looks at the buffers once the walk is over
                if (since_tlast >= 181 && fb_ready_to_switch == 2'b11) begin
                    switch_pending = 1'b0;
                    expect_ready   = 1'b1;
                end
            end
            if (dda_fifo_tvalid && dda_fifo_tready) begin
                seen_accept = 1'b1;
                for (int r = 0; r < 180; r++) begin
                    expected_q.push_back(expected_write(dda_fifo_tdata, r, map_select,
                                                        dda_fifo_tlast));
                end
                if (dda_fifo_tlast) begin
                    switch_pending = 1'b1;
                    since_tlast    = 0;
                end
            end
            if (run_done && !drain_checked) begin
                drain_checked = 1'b1;
                if (expected_q.size() != 0) begin
                    report_protocol($sformatf("%0d expected writes never arrived",
                                              expected_q.size()));
                end
            end
        end
    end

endmodule

//--- tb_column_flattener.sv
module tb_column_flattener;
    timeunit 1ns;
    timeprecision 1ps;
    import raycast_pkg::*;

    localparam int CLK_PERIOD         = 40;
    localparam int RESET_CYCLES       = 16;
    localparam int NUM_PACKETS        = 3;
    localparam int COLUMNS_PER_PACKET = 4;
    localparam int MAX_GAP            = 6;    // idle cycles with tvalid low
    localparam int MAX_HOLD           = 20;   // frame switch delay after a tlast column
    // every column walks 180 rows plus gap and handshake, every packet waits for a switch
    localparam int TIMEOUT_CYCLES = (RESET_CYCLES
        + NUM_PACKETS * COLUMNS_PER_PACKET * (180 + MAX_GAP + 4)
        + NUM_PACKETS * (MAX_HOLD + 8)) * 5 / 4;

    logic                 pixel_clk_in;
    logic                 rst_in;
    logic                 dda_fifo_tvalid;
    column_t              dda_fifo_tdata;
    logic                 dda_fifo_tlast;
    logic                 dda_fifo_tready;
    logic [1:0]           fb_ready_to_switch;
    logic [1:0]           map_select;
    logic [FB_ADDR_W-1:0] ray_address;
    fb_pixel_t            ray_pixel;
    logic                 ray_pixel_valid;
    logic                 ray_last_pixel;
    logic                 run_done;
    int                   value_errors;
    int                   protocol_errors;
    int                   cycle_count = 0;
    logic [31:0]          lcg_state;

    column_flattener i_column_flattener (
        .pixel_clk_in       (pixel_clk_in),
        .rst_in             (rst_in),
        .dda_fifo_tvalid    (dda_fifo_tvalid),
        .dda_fifo_tdata     (dda_fifo_tdata),
        .dda_fifo_tlast     (dda_fifo_tlast),
        .dda_fifo_tready    (dda_fifo_tready),
        .fb_ready_to_switch (fb_ready_to_switch),
        .map_select         (map_select),
        .ray_address        (ray_address),
        .ray_pixel          (ray_pixel),
        .ray_pixel_valid    (ray_pixel_valid),
        .ray_last_pixel     (ray_last_pixel)
    );

    column_flattener_checker i_column_flattener_checker (
        .pixel_clk_in       (pixel_clk_in),
        .rst_in             (rst_in),
        .dda_fifo_tvalid    (dda_fifo_tvalid),
        .dda_fifo_tdata     (dda_fifo_tdata),
        .dda_fifo_tlast     (dda_fifo_tlast),
        .dda_fifo_tready    (dda_fifo_tready),
        .fb_ready_to_switch (fb_ready_to_switch),
        .map_select         (map_select),
        .ray_address        (ray_address),
        .ray_pixel          (ray_pixel),
        .ray_pixel_valid    (ray_pixel_valid),
        .ray_last_pixel     (ray_last_pixel),
        .run_done           (run_done),
        .value_errors       (value_errors),
        .protocol_errors    (protocol_errors)
    );

    initial begin
        pixel_clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) pixel_clk_in = ~pixel_clk_in;
    end

    // numerical recipes constants
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[30:8]) % n;  // low bits of an lcg cycle too fast
    endfunction

    // column k of the run, the first few pinned to corner cases
    function automatic column_t make_column(int k);
        column_t c;
        c.hcount    = (k == 2) ? 9'd319 : 9'(rand_below(320));  // right screen edge once
        c.wall_type = (rand_below(2) != 0);
        c.wall_x    = 16'(rand_below(65536));  // carried, never drawn
        case (k)
            0:       c.line_height = 8'd0;      // no wall, sky meets floor at 90
            1:       c.line_height = 8'd180;    // wall fills the column
            default: c.line_height = 8'(rand_below(181));
        endcase
        case (k % 4)
            0:       c.map_data = 5'(23 + rand_below(4));   // one of the neons
            1:       c.map_data = (k < 4) ? 5'd0 : 5'd1;    // see-through, then plain solid
            default: c.map_data = 5'(rand_below(32));
        endcase
        return c;
    endfunction

    task automatic send_column(input column_t col, input logic last);
        int gap;
        gap = (rand_below(2) == 0) ? 0 : 1 + rand_below(MAX_GAP);
        while (!dda_fifo_tready) @(negedge pixel_clk_in);  // previous column still walking
        repeat (gap) @(negedge pixel_clk_in);              // fifo open, nothing offered
        dda_fifo_tdata  = col;
        dda_fifo_tlast  = last;
        dda_fifo_tvalid = 1'b1;
        while (!dda_fifo_tready) @(negedge pixel_clk_in);
        @(negedge pixel_clk_in);  // handshake on the rising edge just passed
        dda_fifo_tvalid = 1'b0;
    endtask

    // after a tlast column, keep offering a word the DUT has to refuse
    task automatic frame_switch(input logic [1:0] next_map);
        int hold;
        dda_fifo_tdata  = make_column(NUM_PACKETS * COLUMNS_PER_PACKET);
        dda_fifo_tlast  = 1'b0;
        dda_fifo_tvalid = 1'b1;
        while (!ray_last_pixel) @(negedge pixel_clk_in);  // frame fully written
        hold = rand_below(MAX_HOLD + 1);
        repeat (hold) begin
            fb_ready_to_switch = 2'(rand_below(3));  // one buffer at most
            @(negedge pixel_clk_in);
        end
        dda_fifo_tvalid    = 1'b0;
        map_select         = next_map;  // no column in flight here
        fb_ready_to_switch = 2'b11;
        @(negedge pixel_clk_in);
        fb_ready_to_switch = 2'b00;
    endtask

    initial begin
        lcg_state          = 32'h8459_31e0;
        rst_in             = 1'b1;
        dda_fifo_tvalid    = 1'b0;
        dda_fifo_tdata     = '0;
        dda_fifo_tlast     = 1'b0;
        fb_ready_to_switch = 2'b00;
        map_select         = 2'd0;
        run_done           = 1'b0;
        repeat (RESET_CYCLES) @(negedge pixel_clk_in);
        rst_in = 1'b0;
        repeat (3) @(negedge pixel_clk_in);  // idle outputs after reset
        for (int p = 0; p < NUM_PACKETS; p++) begin
            for (int c = 0; c < COLUMNS_PER_PACKET; c++) begin
                send_column(make_column(p * COLUMNS_PER_PACKET + c),
                            (c == COLUMNS_PER_PACKET - 1));
            end
            frame_switch(2'(3 - p));  // maps 0, 3, 2 cover both palettes
        end
        run_done = 1'b1;
        repeat (2) @(negedge pixel_clk_in);
        $display("run complete: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    always @(posedge pixel_clk_in) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

endmodule

//--- compile.f
raycast_pkg.sv
column_sequencer.sv
color_picker.sv
address_generator.sv
pixel_writer.sv
column_flattener.sv
column_flattener_checker.sv
tb_column_flattener.sv

//--- Makefile
TOP = tb_column_flattener

.PHONY: all lint sim clean

all: sim

# static checks on the RTL and the testbench together
lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

# build and run, pass only if the log holds the pass message
sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
